//--- rtl/monitor_pkg.sv
package monitor_pkg;

  // data path widths
  typedef logic [31:0]  beat_t;      // one AXI read beat
  typedef logic [31:0]  addr_t;      // AXI byte address
  typedef logic [127:0] seg_t;       // four beats gathered
  typedef logic [135:0] pkt_word_t;  // kind, pad, payload
  typedef logic [9:0]   index_t;     // packet index
  typedef logic [1:0]   kind_t;

  // burst and frame geometry
  localparam int BEATS_PER_BURST  = 4;   // ar_len is this minus one
  localparam int BURST_BYTES      = 16;  // address step per burst
  localparam int BURSTS_PER_FRAME = 8;
  localparam int SEGS_PER_PKT     = 4;
  localparam int SEG_FIFO_DEPTH   = 4;

  // index runs 0..INDEX_LAST then wraps
  localparam index_t INDEX_LAST = 10'd5;

  // frame buffers in DDR
  localparam addr_t BUF0_BASE = 32'h2BC0_0000;  // even frames
  localparam addr_t BUF1_BASE = 32'h2BE0_0000;  // odd frames

  // packet word kinds
  localparam kind_t KIND_HDR  = 2'd2;
  localparam kind_t KIND_BODY = 2'd0;

  // fixed header fields
  localparam logic [47:0] DST_MAC  = 48'hABAB_ABAB_ABAB;
  localparam logic [47:0] SRC_MAC  = 48'hACAC_ACAC_ACAC;
  localparam logic [15:0] ETH_TYPE = 16'h9000;

endpackage

//--- rtl/seg_stream_if.sv
interface seg_stream_if;
  import monitor_pkg::*;

  seg_t seg_data;
  logic seg_valid;
  logic seg_ready;
  logic seg_last;   // final segment of the frame

  // FIFO head, driven from inside the reader
  modport source (output seg_data, output seg_valid, output seg_last,
                  input seg_ready);

  // packet assembler side
  modport sink (input seg_data, input seg_valid, input seg_last,
                output seg_ready);

endinterface

//--- rtl/seg_fifo.sv
module seg_fifo #(
  parameter int DEPTH = monitor_pkg::SEG_FIFO_DEPTH
) (
  input  logic               clk,
  input  logic               aresetn,
  input  monitor_pkg::seg_t  wr_data,
  input  logic               wr_last,
  input  logic               wr_en,
  output logic               full,
  seg_stream_if.source       out
);
  import monitor_pkg::*;

  seg_t                         mem [DEPTH];
  logic                         last_mem [DEPTH];  // frame end flag per entry
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         do_wr;
  logic                         do_rd;

  assign full  = count == DEPTH;
  assign do_wr = wr_en && !full;
  assign do_rd = out.seg_valid && out.seg_ready;

  // head of queue shown directly on the stream
  assign out.seg_valid = count != 0;
  assign out.seg_data  = mem[rd_ptr];
  assign out.seg_last  = last_mem[rd_ptr];

  always_ff @(posedge clk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (do_wr && !do_rd) count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr]      <= wr_data;
      last_mem[wr_ptr] <= wr_last;
    end
  end

endmodule

//--- rtl/frame_reader.sv
module frame_reader (
  input  logic                clk,
  input  logic                aresetn,
  input  logic                start_valid,
  output logic                start_ready,
  input  logic                odd_even,
  output logic                finish_valid,
  input  logic                finish_ready,
  output monitor_pkg::addr_t  ar_addr,
  output logic [7:0]          ar_len,
  output logic [2:0]          ar_size,
  output logic [1:0]          ar_burst,
  output logic                ar_valid,
  input  logic                ar_ready,
  input  monitor_pkg::beat_t  r_data,
  input  logic                r_last,
  input  logic                r_valid,
  output logic                r_ready,
  seg_stream_if.source        seg
);
  import monitor_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE, ST_ADDR, ST_DATA, ST_QUEUE, ST_FINISH
  } state_t;

  state_t                                 state;
  logic [$clog2(BURSTS_PER_FRAME)-1:0]    burst_cnt;
  logic [$clog2(BEATS_PER_BURST)-1:0]     beat_cnt;
  seg_t                                   gather;
  seg_t                                   gather_next;
  seg_t                                   fifo_data;
  logic                                   fifo_wr;
  logic                                   fifo_full;
  logic                                   r_fire;
  logic                                   last_burst;

  // fixed burst shape
  assign ar_len   = 8'(BEATS_PER_BURST - 1);
  assign ar_size  = 3'($clog2($bits(beat_t) / 8));  // 4 bytes per beat
  assign ar_burst = 2'b01;                           // INCR

  assign start_ready  = state == ST_IDLE;
  assign ar_valid     = state == ST_ADDR;
  assign r_ready      = state == ST_DATA;
  assign finish_valid = state == ST_FINISH;

  assign r_fire     = r_valid && r_ready;
  assign last_burst = burst_cnt == BURSTS_PER_FRAME - 1;

  // first beat lands in the lowest word
  always_comb begin
    gather_next = gather;
    gather_next[beat_cnt*$bits(beat_t) +: $bits(beat_t)] = r_data;
  end

  // closing beat goes straight in when there is room, else parked in gather
  assign fifo_wr   = (state == ST_QUEUE || (r_fire && r_last)) && !fifo_full;
  assign fifo_data = (state == ST_QUEUE) ? gather : gather_next;

  always_ff @(posedge clk or negedge aresetn) begin
    if (!aresetn) begin
      state     <= ST_IDLE;
      burst_cnt <= '0;
      beat_cnt  <= '0;
    end else begin
      case (state)
        ST_IDLE: if (start_valid) begin
          burst_cnt <= '0;
          state     <= ST_ADDR;
        end
        ST_ADDR: if (ar_ready) begin
          beat_cnt <= '0;
          state    <= ST_DATA;
        end
        ST_DATA: if (r_fire) begin
          beat_cnt <= beat_cnt + 1'b1;
          if (r_last) begin
            if (fifo_full) begin
              state <= ST_QUEUE;
            end else begin
              burst_cnt <= burst_cnt + 1'b1;
              state     <= last_burst ? ST_FINISH : ST_ADDR;
            end
          end
        end
        ST_QUEUE: if (!fifo_full) begin
          burst_cnt <= burst_cnt + 1'b1;
          state     <= last_burst ? ST_FINISH : ST_ADDR;
        end
        ST_FINISH: if (finish_ready) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address and gather payload
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start_valid) ar_addr <= odd_even ? BUF1_BASE : BUF0_BASE;
    else if (ar_valid && ar_ready) ar_addr <= ar_addr + addr_t'(BURST_BYTES);
    if (r_fire) gather <= gather_next;
  end

  seg_fifo #(
    .DEPTH (SEG_FIFO_DEPTH)
  ) seg_fifo_i (
    .clk     (clk),
    .aresetn (aresetn),
    .wr_data (fifo_data),
    .wr_last (last_burst),
    .wr_en   (fifo_wr),
    .full    (fifo_full),
    .out     (seg)
  );

endmodule

//--- rtl/header_builder.sv
module header_builder #(
  parameter monitor_pkg::index_t LAST_INDEX = monitor_pkg::INDEX_LAST
) (
  input  logic                    clk,
  input  logic                    aresetn,
  output monitor_pkg::pkt_word_t  hdr_word,
  output logic                    hdr_valid,
  input  logic                    hdr_ready
);
  import monitor_pkg::*;

  index_t pkt_index;

  always_ff @(posedge clk or negedge aresetn) begin
    if (!aresetn) begin
      pkt_index <= '0;
      hdr_valid <= 1'b0;
    end else begin
      hdr_valid <= 1'b1;  // header always ready once out of reset
      if (hdr_ready) begin
        if (pkt_index == LAST_INDEX) pkt_index <= '0;
        else pkt_index <= pkt_index + 1'b1;
      end
    end
  end

  // no room for the timestamp field in a 128-bit payload
  assign hdr_word = {
    KIND_HDR,
    6'b0,
    DST_MAC,       // [127:80]
    SRC_MAC,       // [79:32]
    ETH_TYPE,      // [31:16]
    6'b0,
    pkt_index      // [9:0]
  };

endmodule

//--- rtl/packet_assembler.sv
module packet_assembler (
  input  logic                    clk,
  input  logic                    aresetn,
  seg_stream_if.sink              seg,
  input  monitor_pkg::pkt_word_t  hdr_word,
  input  logic                    hdr_valid,
  output logic                    hdr_ready,
  output monitor_pkg::pkt_word_t  pkt_data,
  output logic                    pkt_valid,
  output logic                    pkt_last,
  input  logic                    pkt_alf
);
  import monitor_pkg::*;

  typedef enum logic {ST_HDR, ST_BODY} state_t;

  state_t                             state;
  logic [$clog2(SEGS_PER_PKT)-1:0]    seg_cnt;  // body words sent in this packet
  logic                               seg_fire;
  logic                               pkt_end;

  // header only goes out once a body segment is waiting
  assign hdr_ready = state == ST_HDR && !pkt_alf && seg.seg_valid && hdr_valid;
  assign seg.seg_ready = state == ST_BODY && !pkt_alf;
  assign seg_fire = seg.seg_valid && seg.seg_ready;

  // frame end also closes a packet
  assign pkt_end = seg_cnt == SEGS_PER_PKT - 1 || seg.seg_last;

  always_ff @(posedge clk or negedge aresetn) begin
    if (!aresetn) begin
      state     <= ST_HDR;
      seg_cnt   <= '0;
      pkt_valid <= 1'b0;
      pkt_last  <= 1'b0;
    end else begin
      pkt_valid <= 1'b0;
      pkt_last  <= 1'b0;
      case (state)
        ST_HDR: if (hdr_ready) begin
          pkt_valid <= 1'b1;
          seg_cnt   <= '0;
          state     <= ST_BODY;
        end
        ST_BODY: if (seg_fire) begin
          pkt_valid <= 1'b1;
          seg_cnt   <= seg_cnt + 1'b1;
          if (pkt_end) begin
            pkt_last <= 1'b1;
            state    <= ST_HDR;
          end
        end
        default: state <= ST_HDR;
      endcase
    end
  end

  // output word, loaded only on a send
  always_ff @(posedge clk) begin
    if (hdr_ready) pkt_data <= hdr_word;
    else if (seg_fire) pkt_data <= {KIND_BODY, 6'b0, seg.seg_data};
  end

endmodule

//--- rtl/monitor_adaptor.sv
module monitor_adaptor (
  input  logic                    clk,
  input  logic                    aresetn,
  input  logic                    start_valid,
  output logic                    start_ready,
  input  logic                    odd_even,
  output logic                    finish_valid,
  input  logic                    finish_ready,
  output monitor_pkg::addr_t      ar_addr,
  output logic [7:0]              ar_len,
  output logic [2:0]              ar_size,
  output logic [1:0]              ar_burst,
  output logic                    ar_valid,
  input  logic                    ar_ready,
  input  monitor_pkg::beat_t      r_data,
  input  logic                    r_last,
  input  logic                    r_valid,
  output logic                    r_ready,
  output monitor_pkg::pkt_word_t  pkt_data,
  output logic                    pkt_valid,
  output logic                    pkt_last,
  input  logic                    pkt_alf
);
  import monitor_pkg::*;

  pkt_word_t hdr_word;
  logic      hdr_valid;
  logic      hdr_ready;

  seg_stream_if seg_if ();  // reader fifo to assembler

  frame_reader frame_reader_i (
    .clk          (clk),
    .aresetn      (aresetn),
    .start_valid  (start_valid),
    .start_ready  (start_ready),
    .odd_even     (odd_even),
    .finish_valid (finish_valid),
    .finish_ready (finish_ready),
    .ar_addr      (ar_addr),
    .ar_len       (ar_len),
    .ar_size      (ar_size),
    .ar_burst     (ar_burst),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .r_data       (r_data),
    .r_last       (r_last),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .seg          (seg_if.source)
  );

  header_builder #(
    .LAST_INDEX (INDEX_LAST)
  ) header_builder_i (
    .clk       (clk),
    .aresetn   (aresetn),
    .hdr_word  (hdr_word),
    .hdr_valid (hdr_valid),
    .hdr_ready (hdr_ready)
  );

  packet_assembler packet_assembler_i (
    .clk       (clk),
    .aresetn   (aresetn),
    .seg       (seg_if.sink),
    .hdr_word  (hdr_word),
    .hdr_valid (hdr_valid),
    .hdr_ready (hdr_ready),
    .pkt_data  (pkt_data),
    .pkt_valid (pkt_valid),
    .pkt_last  (pkt_last),
    .pkt_alf   (pkt_alf)
  );

endmodule

//--- verification/ddr_read_model.sv
module ddr_read_model (
  input  logic                clk,
  input  logic                aresetn,
  input  monitor_pkg::addr_t  ar_addr,
  input  logic                ar_valid,
  output logic                ar_ready,
  output monitor_pkg::beat_t  r_data,
  output logic                r_last,
  output logic                r_valid,
  input  logic                r_ready
);
  timeunit 1ns;
  timeprecision 100ps;
  import monitor_pkg::*;

  addr_t      burst_addr;
  logic [1:0] beat_idx;    // beat currently on the R channel
  logic [1:0] delay;       // cycles left before the first beat
  logic       busy;

  always @(posedge clk or negedge aresetn) begin
    if (!aresetn) begin
      ar_ready   <= 1'b0;
      r_valid    <= 1'b0;
      r_last     <= 1'b0;
      r_data     <= '0;
      busy       <= 1'b0;
      delay      <= '0;
      beat_idx   <= '0;
      burst_addr <= '0;
    end else if (!busy) begin
      ar_ready <= ar_valid && !ar_ready;  // one-cycle ready pulse
      if (ar_valid && ar_ready) begin
        burst_addr <= ar_addr;
        delay      <= 2'($urandom_range(3, 0));
        busy       <= 1'b1;
      end
    end else if (delay != 0) begin
      delay <= delay - 1'b1;
    end else if (!r_valid) begin
      r_valid  <= 1'b1;
      r_data   <= burst_addr;  // each beat carries its own byte address
      r_last   <= 1'b0;
      beat_idx <= '0;
    end else if (r_ready) begin
      beat_idx <= beat_idx + 1'b1;
      r_data   <= burst_addr + 32'(4 * (beat_idx + 1));
      r_last   <= beat_idx == 2'd2;
      if (r_last) begin
        r_valid <= 1'b0;
        busy    <= 1'b0;
      end
    end
  end

endmodule

//--- verification/monitor_adaptor_assert.sv
module monitor_adaptor_assert (
  input  logic                clk,
  input  logic                aresetn,
  input  monitor_pkg::addr_t  ar_addr,
  input  logic                ar_valid,
  input  logic                ar_ready,
  input  logic                pkt_valid,
  input  logic                pkt_alf,
  input  logic                finish_valid,
  input  logic                finish_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  // address request held steady until taken
  ar_hold: assert property (@(posedge clk) disable iff (!aresetn)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else $error("AR valid dropped or address moved before ar_ready");

  alf_pause: assert property (@(posedge clk) disable iff (!aresetn)
    pkt_alf |=> !pkt_valid)
    else $error("pkt_valid high in the cycle after pkt_alf");

  finish_hold: assert property (@(posedge clk) disable iff (!aresetn)
    finish_valid && !finish_ready |=> finish_valid)
    else $error("finish_valid dropped before finish_ready");

endmodule

//--- verification/tb_monitor_adaptor.sv
module tb_monitor_adaptor;
  timeunit 1ns;
  timeprecision 100ps;
  import monitor_pkg::*;

  typedef struct packed {
    logic       odd_even;
    logic       alf_random;  // random pkt_alf pulses during the frame
    logic [3:0] fin_delay;   // cycles before finish_ready
    addr_t      exp_base;
  } row_t;

  logic       clk;
  logic       aresetn;
  logic       start_valid, start_ready, odd_even;
  logic       finish_valid, finish_ready;
  addr_t      ar_addr;
  logic [7:0] ar_len;
  logic [2:0] ar_size;
  logic [1:0] ar_burst;
  logic       ar_valid, ar_ready;
  beat_t      r_data;
  logic       r_last, r_valid, r_ready;
  pkt_word_t  pkt_data;
  logic       pkt_valid, pkt_last, pkt_alf;

  row_t      rows [4];
  pkt_word_t got_data [$];
  logic      got_last [$];
  addr_t     cur_base;
  addr_t     prev_ar_addr;
  int        ar_count;
  int        fin_rises;
  int        mismatches;
  int        failures;
  index_t    exp_index;
  logic      alf_random;
  logic      frame_busy;  // between accepted start and finish handshake
  logic      prev_alf, prev_ar_wait, prev_fin_wait, prev_fin;

  monitor_adaptor dut_i (.*);
  ddr_read_model ddr_i (.*);
  bind monitor_adaptor monitor_adaptor_assert assert_i (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  task automatic flag_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    mismatches++;
  endtask

  task automatic close_run();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    $display("timed out while waiting for %s", what);
    failures++;
    close_run();
  endtask

  // kind on top, MACs and type below, index at the bottom
  function automatic pkt_word_t header_for(index_t idx);
    pkt_word_t w;
    w = '0;
    w[135:134] = KIND_HDR;
    w[127:80]  = DST_MAC;
    w[79:32]   = SRC_MAC;
    w[31:16]   = ETH_TYPE;
    w[9:0]     = idx;
    return w;
  endfunction

  function automatic pkt_word_t body_for(addr_t base, int n);
    pkt_word_t w;
    w = '0;
    w[135:134] = KIND_BODY;
    for (int k = 0; k < 4; k++) w[32*k +: 32] = base + 32'(16 * n + 4 * k);
    return w;
  endfunction

  always @(posedge clk) pkt_alf <= aresetn && alf_random && $urandom_range(3, 0) == 0;

  // AR checks and output capture
  always @(posedge clk) begin
    if (aresetn && ar_valid && ar_ready) begin
      if (ar_len != 8'd3 || ar_size != 3'd2 || ar_burst != 2'b01)
        flag_mismatch($sformatf("AR len %0d size %0d burst %0d", ar_len, ar_size, ar_burst));
      if (ar_addr != cur_base + 32'(16 * ar_count))
        flag_mismatch($sformatf("AR %0d addr %h, expected %h", ar_count, ar_addr,
                                cur_base + 32'(16 * ar_count)));
      ar_count++;
    end
    if (aresetn && pkt_valid) begin
      got_data.push_back(pkt_data);
      got_last.push_back(pkt_last);
    end
  end

  // handshake rules with one cycle of history
  always @(posedge clk) begin
    if (aresetn) begin
      if (start_ready == frame_busy) flag_mismatch("start_ready wrong for frame state");
      if (prev_alf && pkt_valid) flag_mismatch("pkt_valid in the cycle after pkt_alf");
      if (prev_ar_wait && (!ar_valid || ar_addr != prev_ar_addr))
        flag_mismatch("AR changed before ar_ready");
      if (prev_fin_wait && !finish_valid) flag_mismatch("finish_valid dropped early");
      if (finish_valid && !prev_fin) fin_rises++;
      if (start_valid && start_ready) frame_busy <= 1'b1;
      if (finish_valid && finish_ready) frame_busy <= 1'b0;
    end else begin
      frame_busy <= 1'b0;
    end
    prev_alf      <= pkt_alf;
    prev_ar_wait  <= ar_valid && !ar_ready;
    prev_ar_addr  <= ar_addr;
    prev_fin_wait <= finish_valid && !finish_ready;
    prev_fin      <= finish_valid;
  end

  task automatic run_frame(input row_t row);
    int n;
    cur_base   = row.exp_base;
    ar_count   = 0;
    fin_rises  = 0;
    alf_random = row.alf_random;
    got_data.delete();
    got_last.delete();
    odd_even    <= row.odd_even;
    start_valid <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 100) fail_timeout("start_ready");
    end while (!start_ready);
    start_valid <= 1'b0;
    n = 0;
    while (!finish_valid) begin
      @(posedge clk);
      n++;
      if (n > 400) fail_timeout("finish_valid");
    end
    repeat (row.fin_delay) @(posedge clk);
    finish_ready <= 1'b1;
    @(posedge clk);
    finish_ready <= 1'b0;
    if (!finish_valid) flag_mismatch("finish_valid low at the finish handshake");
    n = 0;
    while (got_data.size() < 10) begin
      @(posedge clk);
      n++;
      if (n > 400) fail_timeout("ten output words");
    end
    for (int p = 0; p < 2; p++) begin
      if (got_data[5*p] !== header_for(exp_index) || got_last[5*p] !== 1'b0)
        flag_mismatch($sformatf("header %0d is %h, expected index %0d", p, got_data[5*p],
                                exp_index));
      exp_index = (exp_index == INDEX_LAST) ? '0 : exp_index + 1'b1;
      for (int j = 0; j < 4; j++) begin
        if (got_data[5*p+1+j] !== body_for(row.exp_base, 4*p+j))
          flag_mismatch($sformatf("body %0d is %h", 4*p+j, got_data[5*p+1+j]));
        if (got_last[5*p+1+j] !== (j == 3))
          flag_mismatch($sformatf("pkt_last %b on body %0d", got_last[5*p+1+j], 4*p+j));
      end
    end
    if (ar_count != 8 || fin_rises != 1)
      flag_mismatch($sformatf("%0d ARs and %0d finish rises in the frame", ar_count,
                              fin_rises));
  endtask

  initial begin
    void'($urandom(43));
    rows[0] = '{1'b0, 1'b0, 4'd0, BUF0_BASE};
    rows[1] = '{1'b1, 1'b0, 4'd3, BUF1_BASE};
    rows[2] = '{1'b0, 1'b1, 4'd1, BUF0_BASE};
    rows[3] = '{1'b1, 1'b1, 4'd6, BUF1_BASE};
    mismatches   = 0;
    failures     = 0;
    exp_index    = '0;
    alf_random   = 1'b0;
    ar_count     = 0;
    fin_rises    = 0;
    cur_base     = BUF0_BASE;
    aresetn      <= 1'b0;
    start_valid  <= 1'b0;
    odd_even     <= 1'b0;
    finish_ready <= 1'b0;
    pkt_alf      <= 1'b0;
    repeat (8) @(posedge clk);
    aresetn <= 1'b1;
    repeat (3) @(posedge clk);
    if (!start_ready || finish_valid || ar_valid || r_ready || pkt_valid)
      flag_mismatch("outputs not idle after reset");
    foreach (rows[i]) run_frame(rows[i]);
    close_run();
  end

endmodule

//--- tb.f
rtl/monitor_pkg.sv
rtl/seg_stream_if.sv
rtl/seg_fifo.sv
rtl/frame_reader.sv
rtl/header_builder.sv
rtl/packet_assembler.sv
rtl/monitor_adaptor.sv
verification/ddr_read_model.sv
verification/monitor_adaptor_assert.sv
verification/tb_monitor_adaptor.sv

//--- Makefile
TOP = tb_monitor_adaptor

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
